//--- dv/tb_ex_stage.sv
`include "ex_settings.svh"

module tb_ex_stage;

  timeunit 1ns;
  timeprecision 100ps;

  import ex_op_pkg::*;
  import ex_port_pkg::*;

  // Row kinds
  localparam logic [2:0] KIND_ALU = 3'd0;
  localparam logic [2:0] KIND_MUL = 3'd1;
  localparam logic [2:0] KIND_CSR = 3'd2;
  localparam logic [2:0] KIND_LSU = 3'd3;
  localparam logic [2:0] KIND_BR  = 3'd4;
  localparam logic [3:0] OP_MUL   = 4'(MULT_MUL);
  localparam logic [3:0] OP_MULHU = 4'(MULT_MULHU);
  localparam int         SEED     = 55605;

  // One stimulus row, expected value last
  // For LSU rows operand c is the load data, for CSR rows the CSR read data
  typedef struct packed {
    logic [2:0]             kind;
    logic [3:0]             op;
    logic [`EX_RADDR_W-1:0] addr;
    logic [`EX_XLEN-1:0]    a;
    logic [`EX_XLEN-1:0]    b;
    logic [`EX_XLEN-1:0]    c;
    logic                   wb_rdy;
    logic [`EX_XLEN-1:0]    exp;
  } row_t;

  logic                   clk = 1'b0;
  logic                   rst_n;
  alu_req_t               alu_req_i;
  mult_req_t              mult_req_i;
  logic                   csr_access_i;
  logic [`EX_XLEN-1:0]    csr_rdata_i;
  logic                   lsu_en_i;
  logic                   branch_in_ex_i;
  logic                   fw_we_i;
  logic [`EX_RADDR_W-1:0] fw_waddr_i;
  logic                   wb_we_i;
  logic [`EX_RADDR_W-1:0] wb_waddr_i;
  logic [`EX_XLEN-1:0]    lsu_rdata_i;
  logic                   lsu_ready_ex_i;
  logic                   wb_ready_i;
  rf_port_t               rf_fw_o;
  rf_port_t               rf_wb_o;
  logic [`EX_XLEN-1:0]    jump_target_o;
  logic                   branch_decision_o;
  logic                   ex_ready_o;
  logic                   ex_valid_o;

  row_t                   rows[$];
  logic                   table_ready = 1'b0;
  // Expected EX/WB slot as seen on the LSU port
  logic                   exp_we;
  logic [`EX_RADDR_W-1:0] exp_waddr;
  logic [`EX_XLEN-1:0]    exp_data;

  // 8 ns clock
  always #4 clk = ~clk;

  ex_stage u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req_i),
    .mult_req_i        (mult_req_i),
    .csr_access_i      (csr_access_i),
    .csr_rdata_i       (csr_rdata_i),
    .lsu_en_i          (lsu_en_i),
    .branch_in_ex_i    (branch_in_ex_i),
    .fw_we_i           (fw_we_i),
    .fw_waddr_i        (fw_waddr_i),
    .wb_we_i           (wb_we_i),
    .wb_waddr_i        (wb_waddr_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .wb_ready_i        (wb_ready_i),
    .rf_fw_o           (rf_fw_o),
    .rf_wb_o           (rf_wb_o),
    .jump_target_o     (jump_target_o),
    .branch_decision_o (branch_decision_o),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run;
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
    $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  task automatic plain_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [`EX_XLEN-1:0] alu_expect(input logic [3:0] op,
                                                     input logic [`EX_XLEN-1:0] a,
                                                     input logic [`EX_XLEN-1:0] b);
    logic [`EX_XLEN-1:0] r;
    r = '0;
    case (alu_op_e'(op))
      ALU_ADD:        r = a + b;
      ALU_SUB:        r = a - b;
      ALU_AND:        r = a & b;
      ALU_OR:         r = a | b;
      ALU_XOR:        r = a ^ b;
      // RV32 shift amount is five bits
      ALU_SLL:        r = a << b[4:0];
      ALU_SRL:        r = a >> b[4:0];
      ALU_SLT, ALU_LT: r[0] = $signed(a) < $signed(b);
      ALU_SLTU:       r[0] = a < b;
      ALU_EQ:         r[0] = a == b;
      ALU_NE:         r[0] = a != b;
      ALU_GE:         r[0] = $signed(a) >= $signed(b);
      default:        r = '0;
    endcase
    return r;
  endfunction

  // Unsigned product, low or high word
  function automatic logic [`EX_XLEN-1:0] mul_expect(input logic op,
                                                     input logic [`EX_XLEN-1:0] a,
                                                     input logic [`EX_XLEN-1:0] b);
    logic [2*`EX_XLEN-1:0] prod;
    prod = {{`EX_XLEN{1'b0}}, a} * {{`EX_XLEN{1'b0}}, b};
    return op ? prod[2*`EX_XLEN-1:`EX_XLEN] : prod[`EX_XLEN-1:0];
  endfunction

  function automatic int expected_cycles(input row_t r);
    if (r.kind == KIND_MUL) return `EX_MULT_STEPS;
    // Branches bypass back-pressure
    if (r.kind == KIND_BR || r.wb_rdy) return 1;
    // WB holds off for two cycles, then releases
    return 3;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////////////////////

  function automatic void add_row(input logic [2:0] kind, input logic [3:0] op,
                                  input logic [`EX_RADDR_W-1:0] addr,
                                  input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b,
                                  input logic [`EX_XLEN-1:0] c, input logic wb_rdy,
                                  input logic [`EX_XLEN-1:0] exp);
    rows.push_back({kind, op, addr, a, b, c, wb_rdy, exp});
  endfunction

  task automatic build_table;
    logic [3:0]             op;
    logic [`EX_RADDR_W-1:0] addr;
    logic [`EX_XLEN-1:0]    a;
    logic [`EX_XLEN-1:0]    b;
    logic [`EX_XLEN-1:0]    c;
    // ALU operations
    add_row(KIND_ALU, ALU_ADD,  6'h01, 32'h0000_0005, 32'h0000_0007, 32'h0, 1'b1, 32'h0000_000c);
    add_row(KIND_ALU, ALU_SUB,  6'h02, 32'h0000_0010, 32'h0000_0020, 32'h0, 1'b1, 32'hffff_fff0);
    add_row(KIND_ALU, ALU_AND,  6'h03, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0, 1'b1, 32'hf000_f000);
    add_row(KIND_ALU, ALU_OR,   6'h04, 32'hf0f0_f0f0, 32'h0f00_0f00, 32'h0, 1'b1, 32'hfff0_fff0);
    add_row(KIND_ALU, ALU_XOR,  6'h05, 32'haaaa_5555, 32'hffff_0000, 32'h0, 1'b1, 32'h5555_5555);
    add_row(KIND_ALU, ALU_SLT,  6'h06, 32'hffff_fffe, 32'h0000_0001, 32'h0, 1'b1, 32'h0000_0001);
    add_row(KIND_ALU, ALU_SLTU, 6'h07, 32'hffff_fffe, 32'h0000_0001, 32'h0, 1'b1, 32'h0000_0000);
    add_row(KIND_ALU, ALU_SLL,  6'h08, 32'h0000_0003, 32'h0000_0024, 32'h0, 1'b1, 32'h0000_0030);
    add_row(KIND_ALU, ALU_SRL,  6'h09, 32'h8000_0000, 32'h0000_001f, 32'h0, 1'b1, 32'h0000_0001);
    // Branch compares, some under back-pressure
    add_row(KIND_BR,  ALU_EQ,   6'h00, 32'h0000_1234, 32'h0000_1234, 32'h8000_0100, 1'b0, 32'h1);
    add_row(KIND_BR,  ALU_NE,   6'h00, 32'h0000_1234, 32'h0000_1234, 32'h8000_0104, 1'b1, 32'h0);
    add_row(KIND_BR,  ALU_LT,   6'h00, 32'hffff_ffff, 32'h0000_0000, 32'h8000_0108, 1'b0, 32'h1);
    add_row(KIND_BR,  ALU_GE,   6'h00, 32'h8000_0000, 32'h7fff_ffff, 32'h8000_010c, 1'b1, 32'h0);
    // Multiplier, back to back
    add_row(KIND_MUL, OP_MUL,   6'h0a, 32'h0001_0003, 32'h0002_0005, 32'h0, 1'b1, 32'h000b_000f);
    add_row(KIND_MUL, OP_MULHU, 6'h0b, 32'h0001_0003, 32'h0002_0005, 32'h0, 1'b1, 32'h0000_0002);
    add_row(KIND_MUL, OP_MULHU, 6'h0c, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 1'b1, 32'hffff_fffe);
    add_row(KIND_MUL, OP_MUL,   6'h0d, 32'hffff_ffff, 32'hffff_ffff, 32'h0, 1'b1, 32'h0000_0001);
    // CSR data beats the ALU sum of the same operands
    add_row(KIND_CSR, ALU_ADD,  6'h0e, 32'h0000_0001, 32'h0000_0002, 32'hc5a0_0001, 1'b1,
            32'hc5a0_0001);
    // Load, then an idle branch drains the slot
    add_row(KIND_LSU, ALU_ADD,  6'h21, 32'h0, 32'h0, 32'hdead_beef, 1'b1, 32'h0);
    add_row(KIND_BR,  ALU_EQ,   6'h00, 32'h0, 32'h0, 32'h0000_0000, 1'b1, 32'h1);
    // Load, then back-pressure holds its slot
    add_row(KIND_LSU, ALU_ADD,  6'h15, 32'h0, 32'h0, 32'h0bad_f00d, 1'b1, 32'h0);
    add_row(KIND_ALU, ALU_ADD,  6'h02, 32'h0000_0003, 32'h0000_0004, 32'h0, 1'b0, 32'h0000_0007);
    add_row(KIND_BR,  ALU_NE,   6'h00, 32'h0000_0005, 32'h0000_0006, 32'h8000_0200, 1'b0, 32'h1);
    // Random rows cycle through ALU, multiplier and branch
    for (int i = 0; i < 12; i++) begin
      a    = $urandom();
      b    = $urandom();
      c    = $urandom();
      addr = `EX_RADDR_W'($urandom());
      case (i % 3)
        0: begin
          op = 4'($urandom_range(8, 0));
          add_row(KIND_ALU, op, addr, a, b, 32'h0, 1'b1, alu_expect(op, a, b));
        end
        1: begin
          op = 4'($urandom_range(1, 0));
          add_row(KIND_MUL, op, addr, a, b, 32'h0, 1'b1, mul_expect(op[0], a, b));
        end
        default: begin
          op = 4'($urandom_range(12, 9));
          add_row(KIND_BR, op, 6'h00, a, b, c, 1'($urandom()), alu_expect(op, a, b));
        end
      endcase
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Row driver and checks
  ////////////////////////////////////////////////////////////////////////////

  // Called just after a rising edge
  task automatic drive_row(input row_t r);
    alu_req_t  areq;
    mult_req_t mreq;
    areq      = '0;
    mreq      = '0;
    areq.en   = (r.kind == KIND_ALU);
    areq.op   = alu_op_e'(r.op);
    areq.op_a = r.a;
    areq.op_b = r.b;
    areq.op_c = r.c;
    mreq.en   = (r.kind == KIND_MUL);
    mreq.op   = mult_op_e'(r.op[0]);
    mreq.op_a = r.a;
    mreq.op_b = r.b;
    alu_req_i      <= areq;
    mult_req_i     <= mreq;
    csr_access_i   <= (r.kind == KIND_CSR);
    csr_rdata_i    <= r.c;
    lsu_en_i       <= (r.kind == KIND_LSU);
    branch_in_ex_i <= (r.kind == KIND_BR);
    fw_we_i        <= (r.kind == KIND_ALU) || (r.kind == KIND_MUL) || (r.kind == KIND_CSR);
    fw_waddr_i     <= r.addr;
    wb_we_i        <= (r.kind == KIND_LSU);
    wb_waddr_i     <= r.addr;
    wb_ready_i     <= r.wb_rdy;
  endtask

  task automatic check_wb_port;
    assert (rf_wb_o.we == exp_we)
      else value_mismatch("rf_wb_o.we", 64'(rf_wb_o.we), 64'(exp_we));
    if (exp_we) begin
      assert (rf_wb_o.waddr == exp_waddr)
        else value_mismatch("rf_wb_o.waddr", 64'(rf_wb_o.waddr), 64'(exp_waddr));
      assert (rf_wb_o.wdata == exp_data)
        else value_mismatch("rf_wb_o.wdata", 64'(rf_wb_o.wdata), 64'(exp_data));
    end
  endtask

  // EX/WB slot after a rising edge, wb_ready_i still holds the old cycle
  task automatic advance_slot(input logic valid, input row_t r);
    if (valid) begin
      exp_we = (r.kind == KIND_LSU);
      if (r.kind == KIND_LSU) begin
        exp_waddr = r.addr;
        exp_data  = r.c;
      end
    end else if (wb_ready_i) begin
      exp_we = 1'b0;
    end
  endtask

  task automatic run_row(input row_t r);
    int   cycles;
    logic exp_valid;
    // Branches write nothing back
    exp_valid = (r.kind != KIND_BR);
    drive_row(r);
    @(negedge clk);
    cycles = 1;
    check_wb_port();
    while (!ex_ready_o) begin
      assert (ex_valid_o == 1'b0)
        else value_mismatch("ex_valid_o", 64'(ex_valid_o), 64'h0);
      assert (cycles <= `EX_MULT_STEPS)
        else plain_failure("The stage stayed stalled longer than a multiply takes");
      @(posedge clk);
      advance_slot(1'b0, r);
      if (!wb_ready_i && cycles >= 2) begin
        wb_ready_i <= 1'b1;
      end
      @(negedge clk);
      cycles++;
      check_wb_port();
    end
    assert (cycles == expected_cycles(r))
      else value_mismatch("ex_ready_o latency", 64'(cycles), 64'(expected_cycles(r)));
    assert (ex_valid_o == exp_valid)
      else value_mismatch("ex_valid_o", 64'(ex_valid_o), 64'(exp_valid));
    if (r.kind == KIND_BR) begin
      assert (branch_decision_o == r.exp[0])
        else value_mismatch("branch_decision_o", 64'(branch_decision_o), 64'(r.exp[0]));
      assert (jump_target_o == r.c)
        else value_mismatch("jump_target_o", 64'(jump_target_o), 64'(r.c));
    end else if (r.kind != KIND_LSU) begin
      assert (rf_fw_o.wdata == r.exp)
        else value_mismatch("rf_fw_o.wdata", 64'(rf_fw_o.wdata), 64'(r.exp));
      assert (rf_fw_o.we == 1'b1)
        else value_mismatch("rf_fw_o.we", 64'(rf_fw_o.we), 64'h1);
      assert (rf_fw_o.waddr == r.addr)
        else value_mismatch("rf_fw_o.waddr", 64'(rf_fw_o.waddr), 64'(r.addr));
    end
    @(posedge clk);
    advance_slot(exp_valid, r);
    // Load data arrives one cycle after acceptance
    if (r.kind == KIND_LSU) begin
      lsu_rdata_i <= r.c;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_n          = 1'b0;
    alu_req_i      = '0;
    mult_req_i     = '0;
    csr_access_i   = 1'b0;
    csr_rdata_i    = '0;
    lsu_en_i       = 1'b0;
    branch_in_ex_i = 1'b0;
    fw_we_i        = 1'b0;
    fw_waddr_i     = '0;
    wb_we_i        = 1'b0;
    wb_waddr_i     = '0;
    lsu_rdata_i    = '0;
    lsu_ready_ex_i = 1'b1;
    wb_ready_i     = 1'b1;
    exp_we         = 1'b0;
    exp_waddr      = '0;
    exp_data       = '0;
    void'($urandom(SEED));
    build_table();
    table_ready = 1'b1;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    // LSU port starts empty
    assert (rf_wb_o.we == 1'b0)
      else value_mismatch("rf_wb_o.we", 64'(rf_wb_o.we), 64'h0);
    @(posedge clk);
    foreach (rows[i]) begin
      run_row(rows[i]);
    end
    $display("All checks passed");
    $finish;
  end

  // Budget covers reset plus a full multiply and slack per row
  initial begin
    wait (table_ready);
    repeat (rows.size() * (`EX_MULT_STEPS + 4) + 8) @(posedge clk);
    $display("Timeout: the stage did not get through the stimulus table in time");
    abort_run();
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module tb_ex_stage -o tb_ex_stage \
  || { echo "Verilator build failed"; exit 1; }

./obj_dir/tb_ex_stage > sim.log 2>&1
cat sim.log

# The log decides the outcome
grep -qx "All checks passed" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- sim.f
+incdir+source
source/ex_op_pkg.sv
source/ex_port_pkg.sv
source/ex_alu.sv
source/ex_mult.sv
source/ex_wb_reg.sv
source/ex_wb_mux.sv
source/ex_stage.sv
dv/tb_ex_stage.sv

//--- source/ex_alu.sv
`include "ex_settings.svh"

module ex_alu (
  input  ex_port_pkg::alu_req_t alu_req_i,
  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  cmp_result_o
);

  import ex_op_pkg::*;

  // Shift amount width follows the data width
  localparam int SHAMT_W = $clog2(`EX_XLEN);

  logic [`EX_XLEN:0]   diff;
  logic                lt_u;
  logic                lt_s;
  logic                eq;
  logic [SHAMT_W-1:0]  shamt;

  // One wide subtract serves SUB and all magnitude compares
  assign diff  = {1'b0, alu_req_i.op_a} - {1'b0, alu_req_i.op_b};
  // Borrow out means a < b unsigned
  assign lt_u  = diff[`EX_XLEN];
  // Differing signs decide directly, else unsigned order holds
  assign lt_s  = (alu_req_i.op_a[`EX_XLEN-1] ^ alu_req_i.op_b[`EX_XLEN-1]) ?
                 alu_req_i.op_a[`EX_XLEN-1] : lt_u;
  assign eq    = (alu_req_i.op_a == alu_req_i.op_b);
  assign shamt = alu_req_i.op_b[SHAMT_W-1:0];

  // Compare bit for branches and set-less-than
  always_comb begin
    unique case (alu_req_i.op)
      ALU_SLT,
      ALU_LT:   cmp_result_o = lt_s;
      ALU_SLTU: cmp_result_o = lt_u;
      ALU_EQ:   cmp_result_o = eq;
      ALU_NE:   cmp_result_o = ~eq;
      ALU_GE:   cmp_result_o = ~lt_s;
      default:  cmp_result_o = 1'b0;
    endcase
  end

  // Result word
  always_comb begin
    unique case (alu_req_i.op)
      ALU_ADD: result_o = alu_req_i.op_a + alu_req_i.op_b;
      ALU_SUB: result_o = diff[`EX_XLEN-1:0];
      ALU_AND: result_o = alu_req_i.op_a & alu_req_i.op_b;
      ALU_OR:  result_o = alu_req_i.op_a | alu_req_i.op_b;
      ALU_XOR: result_o = alu_req_i.op_a ^ alu_req_i.op_b;
      ALU_SLL: result_o = alu_req_i.op_a << shamt;
      ALU_SRL: result_o = alu_req_i.op_a >> shamt;
      // Compares give a zero-extended flag
      default: result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

//--- source/ex_mult.sv
`include "ex_settings.svh"

module ex_mult (
  input  logic                   clk,
  input  logic                   rst_n,
  input  ex_port_pkg::mult_req_t mult_req_i,
  input  logic                   ex_ready_i,
  output logic [`EX_XLEN-1:0]    result_o,
  output logic                   ready_o
);

  import ex_op_pkg::*;

  localparam int PROD_W = 2 * `EX_XLEN;
  localparam int PP_W   = `EX_XLEN + `EX_MULT_STEP_BITS;

  logic                         busy_q;
  logic [`EX_MULT_CNT_W-1:0]    cnt_q;
  logic [PROD_W-1:0]            acc_q;
  logic [`EX_MULT_STEP_BITS-1:0] b_slice;
  logic [PP_W-1:0]              pp;
  logic [PROD_W-1:0]            pp_shifted;
  logic [PROD_W-1:0]            sum;
  logic                         last_step;

  // Counter sits at zero while idle, so the first slice is taken on start
  assign b_slice    = mult_req_i.op_b[cnt_q*`EX_MULT_STEP_BITS +: `EX_MULT_STEP_BITS];
  assign pp         = mult_req_i.op_a * b_slice;
  assign pp_shifted = {{(PROD_W-PP_W){1'b0}}, pp} << (cnt_q * `EX_MULT_STEP_BITS);
  // Fresh product on start, running total afterwards
  assign sum        = (busy_q ? acc_q : '0) + pp_shifted;
  assign last_step  = busy_q && (cnt_q == `EX_MULT_CNT_W'(`EX_MULT_STEPS - 1));

  // Final slice is added combinationally in the last cycle
  assign result_o = (mult_req_i.op == MULT_MULHU) ? sum[PROD_W-1:`EX_XLEN] :
                                                    sum[`EX_XLEN-1:0];
  // Idle with no request, or finishing
  assign ready_o  = last_step | (~busy_q & ~mult_req_i.en);

  ////////////////////////////////////////////////////////////////////////////
  // Busy flag and step counter
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (mult_req_i.en) begin
        busy_q <= 1'b1;
        cnt_q  <= `EX_MULT_CNT_W'(1);
      end
    end else if (last_step) begin
      // Hold the result until the stage moves on
      if (ex_ready_i) begin
        busy_q <= 1'b0;
        cnt_q  <= '0;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Partial sum, frozen during the final cycle
  always_ff @(posedge clk) begin
    if (!last_step && (busy_q || mult_req_i.en)) begin
      acc_q <= sum;
    end
  end

  // Counter stays inside the slice range
  assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= `EX_MULT_STEPS)
    else $error("ex_mult step counter out of range");

  // ID must hold the request while the iteration runs
  assert property (@(posedge clk) disable iff (!rst_n)
    busy_q |-> $stable(mult_req_i.op_a) && $stable(mult_req_i.op_b) &&
               $stable(mult_req_i.op))
    else $error("ex_mult operands changed while busy");

endmodule

//--- source/ex_op_pkg.sv
package ex_op_pkg;

  //////////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////////

  // Arithmetic and logic ops first, compares last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    // Set-less-than writes the compare bit as a word
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    // Shifts use the low bits of operand b
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    // Branch compares
    ALU_EQ   = 4'd9,
    ALU_NE   = 4'd10,
    ALU_LT   = 4'd11,
    ALU_GE   = 4'd12
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Multiplier operations
  //////////////////////////////////////////////////////////////////////////

  // Both operands are treated as unsigned
  typedef enum logic {
    // Low word of the product
    MULT_MUL   = 1'b0,
    // High word of the product
    MULT_MULHU = 1'b1
  } mult_op_e;

endpackage

//--- source/ex_port_pkg.sv
`include "ex_settings.svh"

package ex_port_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Requests from the ID stage
  //////////////////////////////////////////////////////////////////////////

  // ALU request, 101 bits
  typedef struct packed {
    logic                   en;
    ex_op_pkg::alu_op_e     op;
    logic [`EX_XLEN-1:0]    op_a;
    logic [`EX_XLEN-1:0]    op_b;
    // Branch target travels as operand c
    logic [`EX_XLEN-1:0]    op_c;
  } alu_req_t;

  // Multiplier request, 66 bits
  typedef struct packed {
    logic                   en;
    ex_op_pkg::mult_op_e    op;
    logic [`EX_XLEN-1:0]    op_a;
    logic [`EX_XLEN-1:0]    op_b;
  } mult_req_t;

  //////////////////////////////////////////////////////////////////////////
  // Register file write side
  //////////////////////////////////////////////////////////////////////////

  // One write port, 39 bits
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
    logic [`EX_XLEN-1:0]    wdata;
  } rf_port_t;

  // EX/WB register contents, 7 bits
  // Load data joins later on the LSU port
  typedef struct packed {
    logic                   we;
    logic [`EX_RADDR_W-1:0] waddr;
  } wb_slot_t;

endpackage

//--- source/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Execute stage sizing
////////////////////////////////////////////////////////////////////////////

// Integer datapath width
`define EX_XLEN 32

// Register file address width
// Six bits leave room for a second register bank
`define EX_RADDR_W 6

// Iterations of the shift-and-add multiplier
`define EX_MULT_STEPS 4

// Bits of operand b consumed per multiplier iteration
// EX_MULT_STEPS times EX_MULT_STEP_BITS must equal EX_XLEN
`define EX_MULT_STEP_BITS 8

// Step counter width, wide enough to hold EX_MULT_STEPS itself
`define EX_MULT_CNT_W 3

`endif

//--- source/ex_stage.sv
`include "ex_settings.svh"

module ex_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  // From ID
  input  ex_port_pkg::alu_req_t  alu_req_i,
  input  ex_port_pkg::mult_req_t mult_req_i,
  input  logic                   csr_access_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic                   lsu_en_i,
  input  logic                   branch_in_ex_i,
  input  logic                   fw_we_i,
  input  logic [`EX_RADDR_W-1:0] fw_waddr_i,
  input  logic                   wb_we_i,
  input  logic [`EX_RADDR_W-1:0] wb_waddr_i,
  // From LSU and WB
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   wb_ready_i,
  // Write ports
  output ex_port_pkg::rf_port_t  rf_fw_o,
  output ex_port_pkg::rf_port_t  rf_wb_o,
  // To IF
  output logic [`EX_XLEN-1:0]    jump_target_o,
  output logic                   branch_decision_o,
  // Stall control
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  import ex_port_pkg::*;

  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN-1:0] mult_result;
  logic                mult_ready;
  wb_slot_t            slot_in;
  wb_slot_t            slot_q;

  ////////////////////////////////////////////////////////////////////////////
  // Producers
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .alu_req_i    (alu_req_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .mult_req_i (mult_req_i),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  // Branch outcome and target go straight to IF
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i.op_c;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB buffer and write ports
  ////////////////////////////////////////////////////////////////////////////

  assign slot_in.we    = wb_we_i;
  assign slot_in.waddr = wb_waddr_i;

  ex_wb_reg u_wb_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid_i (ex_valid_o),
    .wb_ready_i (wb_ready_i),
    .slot_i     (slot_in),
    .slot_o     (slot_q)
  );

  ex_wb_mux u_wb_mux (
    .alu_req_i      (alu_req_i),
    .mult_en_i      (mult_req_i.en),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .branch_in_ex_i (branch_in_ex_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .mult_ready_i   (mult_ready),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .csr_rdata_i    (csr_rdata_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .fw_we_i        (fw_we_i),
    .fw_waddr_i     (fw_waddr_i),
    .slot_i         (slot_q),
    .rf_fw_o        (rf_fw_o),
    .rf_wb_o        (rf_wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

endmodule

//--- source/ex_wb_mux.sv
`include "ex_settings.svh"

module ex_wb_mux (
  input  ex_port_pkg::alu_req_t  alu_req_i,
  input  logic                   mult_en_i,
  input  logic                   csr_access_i,
  input  logic                   lsu_en_i,
  input  logic                   branch_in_ex_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   wb_ready_i,
  input  logic                   mult_ready_i,
  input  logic [`EX_XLEN-1:0]    alu_result_i,
  input  logic [`EX_XLEN-1:0]    mult_result_i,
  input  logic [`EX_XLEN-1:0]    csr_rdata_i,
  input  logic [`EX_XLEN-1:0]    lsu_rdata_i,
  input  logic                   fw_we_i,
  input  logic [`EX_RADDR_W-1:0] fw_waddr_i,
  input  ex_port_pkg::wb_slot_t  slot_i,
  output ex_port_pkg::rf_port_t  rf_fw_o,
  output ex_port_pkg::rf_port_t  rf_wb_o,
  output logic                   ex_ready_o,
  output logic                   ex_valid_o
);

  logic units_ready;

  // Forwarding port, enable and address straight from ID
  always_comb begin
    rf_fw_o.we    = fw_we_i;
    rf_fw_o.waddr = fw_waddr_i;
    // CSR wins over multiplier, multiplier over ALU
    if (csr_access_i)      rf_fw_o.wdata = csr_rdata_i;
    else if (mult_en_i)    rf_fw_o.wdata = mult_result_i;
    else if (alu_req_i.en) rf_fw_o.wdata = alu_result_i;
    else                   rf_fw_o.wdata = '0;
  end

  // LSU port pairs the buffered slot with load data
  always_comb begin
    rf_wb_o.we    = slot_i.we;
    rf_wb_o.waddr = slot_i.waddr;
    rf_wb_o.wdata = lsu_rdata_i;
  end

  // ALU is single cycle and never stalls
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches resolve in EX and need no WB slot
  assign ex_ready_o  = units_ready | branch_in_ex_i;
  assign ex_valid_o  = (alu_req_i.en | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  // ID issues to one result source at a time
  always_comb begin
    assert final ($onehot0({alu_req_i.en, mult_en_i, csr_access_i}))
      else $error("ex_wb_mux more than one result source enabled");
  end

endmodule

//--- source/ex_wb_reg.sv
`include "ex_settings.svh"

module ex_wb_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,
  input  ex_port_pkg::wb_slot_t slot_i,
  output ex_port_pkg::wb_slot_t slot_o
);

  logic                   we_q;
  logic [`EX_RADDR_W-1:0] waddr_q;

  // Enable is control state
  // Valid implies WB was ready
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      we_q <= slot_i.we;
    end else if (wb_ready_i) begin
      // Nothing finishing, so the old slot drains out
      we_q <= 1'b0;
    end
  end

  // Address only matters while the enable is set
  always_ff @(posedge clk) begin
    if (ex_valid_i && slot_i.we) begin
      waddr_q <= slot_i.waddr;
    end
  end

  assign slot_o.we    = we_q;
  assign slot_o.waddr = waddr_q;

  // Write enable into the register file must always be defined
  assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(slot_o.we))
    else $error("ex_wb_reg enable unknown");

endmodule
